// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] addr_t;    // byte address
  typedef logic [31:0] inst_t;    // raw instruction word
  typedef logic [5:0]  opcode_t;  // major opcode, inst[31:26]

  // pc register value out of reset
  // first sequential fetch is then 0x1c000000
  localparam addr_t reset_pc = 32'h1bff_fffc;

  localparam opcode_t op_b = 6'b010100;  // unconditional pc-relative branch

  // rom layout
  localparam logic [3:0]  rom_branch_slot = 4'hf;    // addr[5:2] holding a branch
  localparam logic [25:0] rom_branch_offs = 26'd16;  // word offset, +64 bytes

  localparam logic [3:0] lfsr_seed = 4'b1011;  // memory latency generator, nonzero

  // decode to fetch branch feedback
  typedef struct packed {
    logic  stall;   // branch waiting in decode
    logic  taken;   // redirect this cycle
    addr_t target;
  } br_bus_t;

  // fetch side exception info
  typedef struct packed {
    logic  adef;      // misaligned fetch address
    addr_t bad_addr;
  } fs_exc_t;

  // if to id payload
  typedef struct packed {
    fs_exc_t exc;
    addr_t   pc;
    inst_t   inst;
  } fs2ds_t;

  // word stored at byte address a
  // branch slots hold a forward branch, every other word encodes its own address
  function automatic inst_t rom_word(input addr_t a);
    if (a[5:2] == rom_branch_slot) begin
      return {op_b, rom_branch_offs};
    end else begin
      return {6'b0, a[27:2]};
    end
  endfunction

endpackage

`default_nettype wire

// File: verilog/redirect_hold.sv
`timescale 1ns/10ps
`default_nettype none

module redirect_hold (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire                     wb_ex,
  input  wire                     ertn_flush,
  input  wire fetch_pkg::addr_t   csr_ex_entry,
  input  wire fetch_pkg::addr_t   csr_ertn_entry,
  input  wire fetch_pkg::br_bus_t br,
  input  wire fetch_pkg::addr_t   fs_pc,         // pc of the last accepted request
  input  wire                     req_accepted,
  output fetch_pkg::addr_t        nextpc,
  output logic                    redirect_pending
);

  logic             ex_hold;
  logic             ertn_hold;
  logic             br_hold;
  fetch_pkg::addr_t ex_target;
  fetch_pkg::addr_t ertn_target;
  fetch_pkg::addr_t br_target;

  // a redirect that no request picked up yet stays here
  // older, lower priority holds are dropped by a newer exception or ertn
  always_ff @(posedge clk) begin
    if (!resetn || req_accepted) begin
      ex_hold   <= 1'b0;
      ertn_hold <= 1'b0;
      br_hold   <= 1'b0;
    end else if (wb_ex) begin
      ex_hold   <= 1'b1;
      ertn_hold <= 1'b0;
      br_hold   <= 1'b0;
    end else if (ertn_flush) begin
      ertn_hold <= 1'b1;
      br_hold   <= 1'b0;
    end else if (br.taken) begin
      br_hold   <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ex)      ex_target   <= csr_ex_entry;
    if (ertn_flush) ertn_target <= csr_ertn_entry;
    if (br.taken)   br_target   <= br.target;
  end

  always_comb begin
    if (wb_ex)           nextpc = csr_ex_entry;
    else if (ex_hold)    nextpc = ex_target;
    else if (ertn_hold)  nextpc = ertn_target;
    else if (ertn_flush) nextpc = csr_ertn_entry;
    else if (br_hold)    nextpc = br_target;
    else if (br.taken)   nextpc = br.target;
    else                 nextpc = fs_pc + 32'd4;  // sequential
  end

  assign redirect_pending = ex_hold | ertn_hold | br_hold;

  // the request that consumed a redirect must leave nothing behind
  a_hold_consumed: assert property (@(posedge clk) disable iff (!resetn)
    req_accepted |=> !redirect_pending);

endmodule

`default_nettype wire

// File: verilog/inst_sram.sv
`timescale 1ns/10ps
`default_nettype none

module inst_sram (
  input  wire                   clk,
  input  wire                   resetn,
  input  wire                   req,
  input  wire fetch_pkg::addr_t addr,
  output logic                  addr_ok,
  output logic                  data_ok,
  output fetch_pkg::inst_t      rdata
);

  logic             pending;   // one request in flight
  logic [1:0]       wait_cnt;  // cycles left before data_ok
  logic [3:0]       lfsr;
  fetch_pkg::addr_t addr_q;
  logic             accept;

  assign data_ok = pending & (wait_cnt == 2'd0);
  assign addr_ok = ~pending | data_ok;  // next request may overlap the response
  assign accept  = req & addr_ok;

  // x^4 + x^3 + 1, free running
  always_ff @(posedge clk) begin
    if (!resetn) begin
      lfsr <= fetch_pkg::lfsr_seed;
    end else begin
      lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pending  <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (accept) begin
      pending  <= 1'b1;
      wait_cnt <= lfsr[1:0];  // 1 to 4 cycles until data
    end else begin
      if (data_ok) begin
        pending <= 1'b0;
      end
      if (pending && wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) addr_q <= addr;
  end

  // contents follow from the address alone
  assign rdata = fetch_pkg::rom_word(addr_q);

  // a response needs a request taken just before or one still busy
  a_data_needs_req: assert property (@(posedge clk) disable iff (!resetn)
    data_ok |-> $past(accept) || !$past(addr_ok));

  a_latency_bound: assert property (@(posedge clk) disable iff (!resetn)
    accept |=> ##[0:3] data_ok);

endmodule

`default_nettype wire

// File: verilog/if_stage.sv
`timescale 1ns/10ps
`default_nettype none

module if_stage (
  input  wire                     clk,
  input  wire                     resetn,
  // instruction memory
  output logic                    inst_req,
  output fetch_pkg::addr_t        inst_addr,
  input  wire                     addr_ok,
  input  wire                     data_ok,
  input  wire fetch_pkg::inst_t   rdata,
  // decode side
  input  wire                     ds_allowin,
  input  wire fetch_pkg::br_bus_t br,
  // redirects from writeback and csr
  input  wire                     wb_ex,
  input  wire                     ertn_flush,
  input  wire fetch_pkg::addr_t   csr_ex_entry,
  input  wire fetch_pkg::addr_t   csr_ertn_entry,
  output logic                    fs2ds_valid,
  output fetch_pkg::fs2ds_t       fs2ds_bus
);

  logic             pfs_valid;
  logic             fs_valid;   // IF owns a live fetch, outstanding or buffered
  fetch_pkg::addr_t fs_pc;
  logic             fs_wait;    // response still due from memory
  logic             fs_cancel;  // that response belongs to a squashed fetch
  logic             buf_valid;
  fetch_pkg::inst_t buf_inst;

  fetch_pkg::addr_t nextpc;
  logic             redirect_pending;
  logic             redirect;
  logic             live_data;
  logic             fs_ready_go;
  logic             mem_free;
  logic             fs_allowin;
  logic             req_accepted;
  logic             buf_set;

  assign redirect    = wb_ex | ertn_flush | br.taken;
  assign live_data   = data_ok & ~fs_cancel;
  assign fs_ready_go = fs_valid & (buf_valid | live_data);

  // memory slot is free once the pending response shows up
  // this also keeps the address stage quiet while a cancelled response drains
  assign mem_free   = ~fs_wait | data_ok;
  assign fs_allowin = mem_free & (~fs_valid | redirect | fs_ready_go & ds_allowin);

  // no fetch past a branch still sitting in decode
  assign inst_req     = pfs_valid & fs_allowin & ~br.stall;
  assign inst_addr    = nextpc;
  assign req_accepted = inst_req & addr_ok;

  redirect_hold u_redirect (
    .clk              (clk),
    .resetn           (resetn),
    .wb_ex            (wb_ex),
    .ertn_flush       (ertn_flush),
    .csr_ex_entry     (csr_ex_entry),
    .csr_ertn_entry   (csr_ertn_entry),
    .br               (br),
    .fs_pc            (fs_pc),
    .req_accepted     (req_accepted),
    .nextpc           (nextpc),
    .redirect_pending (redirect_pending)
  );

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pfs_valid <= 1'b0;
    end else begin
      pfs_valid <= 1'b1;  // pre-IF always has an address to offer
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fs_valid <= 1'b0;
      fs_pc    <= fetch_pkg::reset_pc;
    end else if (req_accepted) begin
      fs_valid <= 1'b1;
      fs_pc    <= nextpc;
    end else if (redirect || fs_ready_go && ds_allowin) begin
      fs_valid <= 1'b0;  // squashed or handed to decode
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fs_wait   <= 1'b0;
      fs_cancel <= 1'b0;
    end else if (req_accepted) begin
      fs_wait   <= 1'b1;
      fs_cancel <= 1'b0;
    end else if (data_ok) begin
      fs_wait   <= 1'b0;
      fs_cancel <= 1'b0;
    end else if (redirect && fs_wait) begin
      fs_cancel <= 1'b1;  // drop it when data_ok comes
    end
  end

  // decode refused the returned word, keep it
  assign buf_set = fs_valid & live_data & ~buf_valid & ~ds_allowin & ~redirect;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      buf_valid <= 1'b0;
    end else if (buf_set) begin
      buf_valid <= 1'b1;
    end else if (redirect || ds_allowin) begin
      buf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (buf_set) buf_inst <= rdata;
  end

  assign fs2ds_valid = fs_ready_go & ~redirect;

  always_comb begin
    fs2ds_bus.exc.adef     = fs_valid & (|fs_pc[1:0]);
    fs2ds_bus.exc.bad_addr = fs_pc;
    fs2ds_bus.pc           = fs_pc;
    fs2ds_bus.inst         = buf_valid ? buf_inst : rdata;
  end

  // the memory itself must be free to take a new request
  a_one_outstanding: assert property (@(posedge clk) disable iff (!resetn)
    $rose(inst_req) |-> addr_ok);

  a_bus_stable: assert property (@(posedge clk) disable iff (!resetn)
    fs2ds_valid && !ds_allowin |=> $stable(fs2ds_bus));

  // held redirect means the old fetch was already thrown away
  a_pending_empty: assert property (@(posedge clk) disable iff (!resetn)
    redirect_pending |-> !fs_valid);

endmodule

`default_nettype wire

// File: verilog/id_branch.sv
`timescale 1ns/10ps
`default_nettype none

module id_branch (
  input  wire                    clk,
  input  wire                    resetn,
  input  wire                    fs2ds_valid,
  input  wire fetch_pkg::fs2ds_t fs2ds_bus,
  input  wire                    ex_stall,
  input  wire                    flush,       // redirect from writeback
  output logic                   ds_allowin,
  output fetch_pkg::br_bus_t     br,
  output logic                   id_valid,
  output fetch_pkg::addr_t       id_pc,
  output fetch_pkg::inst_t       id_inst,
  output logic                   id_adef
);

  fetch_pkg::fs2ds_t ds_bus;
  logic              is_b;
  logic [25:0]       offs;
  fetch_pkg::addr_t  br_offs;
  logic              br_stall;
  logic              br_taken;

  // execute holds decode while it stalls
  assign ds_allowin = ~id_valid | ~ex_stall;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id_valid <= 1'b0;
    end else if (flush) begin
      id_valid <= 1'b0;
    end else if (ds_allowin) begin
      id_valid <= fs2ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs2ds_valid && ds_allowin) ds_bus <= fs2ds_bus;
  end

  assign is_b    = ds_bus.inst[31:26] == fetch_pkg::op_b;
  assign offs    = ds_bus.inst[25:0];
  assign br_offs = {{4{offs[25]}}, offs, 2'b00};  // words to bytes, sign kept

  assign br_stall = id_valid & is_b & ex_stall;
  assign br_taken = id_valid & is_b & ~ex_stall & ~flush;  // a flushed branch is wrong path

  always_comb begin
    br.stall  = br_stall;
    br.taken  = br_taken;
    br.target = ds_bus.pc + br_offs;
  end

  assign id_pc   = ds_bus.pc;
  assign id_inst = ds_bus.inst;
  assign id_adef = ds_bus.exc.adef;

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
  input  wire                   clk,
  input  wire                   resetn,
  input  wire                   wb_ex,
  input  wire                   ertn_flush,
  input  wire fetch_pkg::addr_t csr_ex_entry,
  input  wire fetch_pkg::addr_t csr_ertn_entry,
  input  wire                   ex_stall,
  output logic                  id_valid,
  output fetch_pkg::addr_t      id_pc,
  output fetch_pkg::inst_t      id_inst,
  output logic                  id_adef
);

  logic               inst_req;
  fetch_pkg::addr_t   inst_addr;
  logic               addr_ok;
  logic               data_ok;
  fetch_pkg::inst_t   rdata;
  logic               fs2ds_valid;
  fetch_pkg::fs2ds_t  fs2ds_bus;
  logic               ds_allowin;
  fetch_pkg::br_bus_t br_zip;
  logic               ds_flush;

  assign ds_flush = wb_ex | ertn_flush;  // either redirect empties decode

  inst_sram u_imem (
    .clk     (clk),
    .resetn  (resetn),
    .req     (inst_req),
    .addr    (inst_addr),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rdata   (rdata)
  );

  if_stage u_if (
    .clk            (clk),
    .resetn         (resetn),
    .inst_req       (inst_req),
    .inst_addr      (inst_addr),
    .addr_ok        (addr_ok),
    .data_ok        (data_ok),
    .rdata          (rdata),
    .ds_allowin     (ds_allowin),
    .br             (br_zip),
    .wb_ex          (wb_ex),
    .ertn_flush     (ertn_flush),
    .csr_ex_entry   (csr_ex_entry),
    .csr_ertn_entry (csr_ertn_entry),
    .fs2ds_valid    (fs2ds_valid),
    .fs2ds_bus      (fs2ds_bus)
  );

  id_branch u_id (
    .clk         (clk),
    .resetn      (resetn),
    .fs2ds_valid (fs2ds_valid),
    .fs2ds_bus   (fs2ds_bus),
    .ex_stall    (ex_stall),
    .flush       (ds_flush),
    .ds_allowin  (ds_allowin),
    .br          (br_zip),
    .id_valid    (id_valid),
    .id_pc       (id_pc),
    .id_inst     (id_inst),
    .id_adef     (id_adef)
  );

endmodule

`default_nettype wire

// File: tests/fetch_checks.svh
`ifndef fetch_checks_svh
`define fetch_checks_svh

int check_count = 0;
int error_count = 0;

task automatic check_addr(input string name, input fetch_pkg::addr_t exp_v,
                          input fetch_pkg::addr_t act_v);
  check_count++;
  if (act_v !== exp_v) begin
    error_count++;
    $display("CHECK FAILED %0s: expected %h, actual %h", name, exp_v, act_v);
  end
endtask

task automatic check_inst(input string name, input fetch_pkg::inst_t exp_v,
                          input fetch_pkg::inst_t act_v);
  check_count++;
  if (act_v !== exp_v) begin
    error_count++;
    $display("CHECK FAILED %0s: expected %h, actual %h", name, exp_v, act_v);
  end
endtask

task automatic check_bit(input string name, input logic exp_v, input logic act_v);
  check_count++;
  if (act_v !== exp_v) begin
    error_count++;
    $display("CHECK FAILED %0s: expected %b, actual %b", name, exp_v, act_v);
  end
endtask

// failures that have no expected value to show
task automatic note_failure(input string msg);
  error_count++;
  $display("%0s", msg);
endtask

`endif

// File: tests/fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

  typedef enum logic [1:0] {rd_none, rd_exc, rd_ertn} redir_kind_t;

  typedef struct {
    string            name;
    int               cycles;
    int               stall_w;   // ex_stall weight out of 8
    redir_kind_t      kind;
    int               redir_at;  // cycle inside the row
    fetch_pkg::addr_t entry;
  } row_t;

  logic             clk;
  logic             resetn;
  logic             wb_ex;
  logic             ertn_flush;
  fetch_pkg::addr_t csr_ex_entry;
  fetch_pkg::addr_t csr_ertn_entry;
  logic             ex_stall;
  logic             id_valid;
  fetch_pkg::addr_t id_pc;
  fetch_pkg::inst_t id_inst;
  logic             id_adef;

  row_t             rows[8];
  bit               table_ready = 1'b0;
  bit               running = 1'b0;
  int               seed;
  string            cur_name = "reset";
  int               row_retired;
  bit               waiting = 1'b0;   // redirect seen, entry not retired yet
  fetch_pkg::addr_t wait_pc;
  fetch_pkg::addr_t exp_pc;

  `include "fetch_checks.svh"

  fetch_top dut0 (
    .clk            (clk),
    .resetn         (resetn),
    .wb_ex          (wb_ex),
    .ertn_flush     (ertn_flush),
    .csr_ex_entry   (csr_ex_entry),
    .csr_ertn_entry (csr_ertn_entry),
    .ex_stall       (ex_stall),
    .id_valid       (id_valid),
    .id_pc          (id_pc),
    .id_inst        (id_inst),
    .id_adef        (id_adef)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // rom contents as the memory map defines them
  function automatic fetch_pkg::inst_t expected_word(input fetch_pkg::addr_t a);
    if (a[5:2] == fetch_pkg::rom_branch_slot) begin
      return {fetch_pkg::op_b, fetch_pkg::rom_branch_offs};
    end else begin
      return {6'b0, a[27:2]};
    end
  endfunction

  function automatic fetch_pkg::addr_t step_pc(input fetch_pkg::addr_t a);
    if (a[5:2] == fetch_pkg::rom_branch_slot) begin
      return a + {4'b0, fetch_pkg::rom_branch_offs, 2'b00};  // taken branch
    end else begin
      return a + 32'd4;
    end
  endfunction

  task automatic set_row(input int i, input string n, input int cyc, input int sw,
                         input redir_kind_t k, input int at, input fetch_pkg::addr_t e);
    rows[i].name     = n;
    rows[i].cycles   = cyc;
    rows[i].stall_w  = sw;
    rows[i].kind     = k;
    rows[i].redir_at = at;
    rows[i].entry    = e;
  endtask

  // outputs are stable mid-cycle, a retire happens on the next rising edge
  always @(negedge clk) begin
    if (running) begin
      if (wb_ex) begin
        waiting = 1'b1;
        wait_pc = csr_ex_entry;
      end else if (ertn_flush) begin
        waiting = 1'b1;
        wait_pc = csr_ertn_entry;
      end
      if (id_valid && !ex_stall) begin
        if (waiting && id_pc === wait_pc) begin
          waiting = 1'b0;
          exp_pc  = wait_pc;
        end
        if (!waiting) begin
          row_retired++;
          check_addr({cur_name, " pc"}, exp_pc, id_pc);
          check_inst({cur_name, " inst"}, expected_word(id_pc), id_inst);
          check_bit({cur_name, " adef"}, |id_pc[1:0], id_adef);
          exp_pc = step_pc(id_pc);  // resync so one slip reports once
        end
      end
    end
  end

  initial begin
    int total;
    int i;
    wait (table_ready);
    total = 0;
    for (i = 0; i < $size(rows); i++) begin
      total += rows[i].cycles;
    end
    #((total + 200) * 10);
    $display("watchdog: run did not complete within %0d cycles", total + 200);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int r;
    int c;
    int row_err0;
    resetn         = 1'b0;
    wb_ex          = 1'b0;
    ertn_flush     = 1'b0;
    csr_ex_entry   = '0;
    csr_ertn_entry = '0;
    ex_stall       = 1'b0;
    seed           = 32'ha5c9;
    exp_pc         = fetch_pkg::reset_pc + 32'd4;

    set_row(0, "seq_nostall",     80,  0, rd_none, 0,  32'h0);
    set_row(1, "exc_aligned",     40,  0, rd_exc,  4,  32'h1c01_0000);
    set_row(2, "rand_stall",      150, 3, rd_exc,  0,  32'h1c01_1000);
    set_row(3, "ertn_stall",      80,  5, rd_ertn, 20, 32'h1c02_0040);
    set_row(4, "exc_misaligned",  40,  0, rd_exc,  8,  32'h1c03_003a);
    set_row(5, "ertn_realign",    50,  2, rd_ertn, 6,  32'h1c04_0000);
    set_row(6, "exc_heavy_stall", 120, 7, rd_exc,  30, 32'h1c05_0010);
    set_row(7, "tail_stall",      80,  4, rd_none, 0,  32'h0);
    table_ready = 1'b1;

    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    check_bit("after reset id_valid", 1'b0, id_valid);
    running = 1'b1;

    @(posedge clk);
    for (r = 0; r < $size(rows); r++) begin
      cur_name    = rows[r].name;
      row_retired = 0;
      row_err0    = error_count;
      for (c = 0; c < rows[r].cycles; c++) begin
        ex_stall       <= ($random(seed) & 7) < rows[r].stall_w;
        wb_ex          <= (rows[r].kind == rd_exc) && (c == rows[r].redir_at);
        ertn_flush     <= (rows[r].kind == rd_ertn) && (c == rows[r].redir_at);
        csr_ex_entry   <= rows[r].entry;
        csr_ertn_entry <= rows[r].entry;
        @(posedge clk);
      end
      if (row_retired == 0) begin
        note_failure({"row ", cur_name, " retired no instruction"});
      end
      if (waiting) begin
        note_failure({"row ", cur_name, " never reached its redirect entry"});
      end
      $display("row %0s: %0d retired, %0d mismatches", cur_name, row_retired,
               error_count - row_err0);
    end

    ex_stall   <= 1'b0;
    wb_ex      <= 1'b0;
    ertn_flush <= 1'b0;
    repeat (4) @(posedge clk);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+tests
verilog/fetch_pkg.sv
verilog/redirect_hold.sv
verilog/inst_sram.sv
verilog/if_stage.sv
verilog/id_branch.sv
verilog/fetch_top.sv
tests/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module fetch_tb -f sources.f -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "ERRORS FOUND" sim.log || ! grep -qx "NO ERRORS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
